/* logic/cam_ctrl_pkg.sv */
// shared types, register offsets and sequencer states for the camera control block
`default_nettype none

package cam_ctrl_pkg;

    // ----------------------------------------------------------------------
    //  vector types
    // ----------------------------------------------------------------------
    typedef logic [9:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    // word index, byte address / 4
    typedef logic [7:0]  regadr_t;
    typedef logic [9:0]  align_pattern_t;
    typedef logic [7:0]  csi_dt_t;
    typedef logic [15:0] csi_wc_t;

    // ----------------------------------------------------------------------
    //  register offsets
    // ----------------------------------------------------------------------
    localparam regadr_t REGADR_CORE_ID       = 8'h00;
    localparam regadr_t REGADR_CORE_VERSION  = 8'h01;
    localparam regadr_t REGADR_POWER_ON      = 8'h04;
    localparam regadr_t REGADR_SEQ_STATUS    = 8'h08;
    localparam regadr_t REGADR_RECV_RESET    = 8'h10;
    localparam regadr_t REGADR_ALIGN_RESET   = 8'h20;
    localparam regadr_t REGADR_ALIGN_PATTERN = 8'h22;
    localparam regadr_t REGADR_ALIGN_STATUS  = 8'h28;
    localparam regadr_t REGADR_CLIP_ENABLE   = 8'h40;
    localparam regadr_t REGADR_CSI_MODE      = 8'h50;
    localparam regadr_t REGADR_CSI_DT        = 8'h52;
    localparam regadr_t REGADR_CSI_WC        = 8'h53;

    // power-up sequencer states, readback value is the encoding
    typedef enum logic [2:0] {
        SEQ_OFF      = 3'd0,
        SEQ_PLL_LOCK = 3'd1,
        SEQ_PHY_SYS  = 3'd2,
        SEQ_PHY_CORE = 3'd3,
        SEQ_PHY_INIT = 3'd4,
        SEQ_RUN      = 3'd5
    } seq_state_t;

endpackage

`default_nettype wire

/* logic/axi4l_reg_port.sv */
// AXI4-Lite slave front end that turns bus transfers into one-cycle register strobes
`timescale 1ns/10ps
`default_nettype none

module axi4l_reg_port (
    input  var logic                    s_axi4l,
    input  var logic                    reset,

    input  var logic                    awvalid,
    output var logic                    awready,
    input  var cam_ctrl_pkg::axi_addr_t awaddr,
    input  var logic                    wvalid,
    output var logic                    wready,
    input  var cam_ctrl_pkg::axi_data_t wdata,
    input  var cam_ctrl_pkg::axi_strb_t wstrb,
    output var logic                    bvalid,
    input  var logic                    bready,
    output var logic [1:0]              bresp,

    input  var logic                    arvalid,
    output var logic                    arready,
    input  var cam_ctrl_pkg::axi_addr_t araddr,
    output var logic                    rvalid,
    input  var logic                    rready,
    output var cam_ctrl_pkg::axi_data_t rdata,
    output var logic [1:0]              rresp,

    output var logic                    wr_en,
    output var cam_ctrl_pkg::regadr_t   wr_adr,
    output var cam_ctrl_pkg::axi_data_t wr_data,
    output var cam_ctrl_pkg::axi_strb_t wr_strb,
    output var cam_ctrl_pkg::regadr_t   rd_adr,
    input  var cam_ctrl_pkg::axi_data_t rd_data
);
    import cam_ctrl_pkg::*;

    logic resp_free;
    logic rd_accept;

    // ----------------------------------------------------------------------
    //  write channel
    // ----------------------------------------------------------------------
    // address and data are taken together, only when the response slot is free
    assign resp_free = !bvalid || bready;
    assign awready   = resp_free && wvalid;
    assign wready    = resp_free && awvalid;

    assign wr_en   = awvalid && wvalid && resp_free;
    assign wr_adr  = regadr_t'(awaddr >> 2);
    assign wr_data = wdata;
    assign wr_strb = wstrb;
    assign bresp   = 2'b00;

    always_ff @(posedge s_axi4l) begin
        if (reset) begin
            bvalid <= 1'b0;
        end else if (wr_en) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    //  read channel
    // ----------------------------------------------------------------------
    assign arready   = !rvalid || rready;
    assign rd_accept = arvalid && arready;
    assign rd_adr    = regadr_t'(araddr >> 2);
    assign rresp     = 2'b00;

    always_ff @(posedge s_axi4l) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // captured on acceptance, held while the master stalls
    always_ff @(posedge s_axi4l) begin
        if (rd_accept) begin
            rdata <= rd_data;
        end
    end

    a_bvalid_hold: assert property (@(posedge s_axi4l) disable iff (reset)
        bvalid && !bready |=> bvalid);

    a_rvalid_hold: assert property (@(posedge s_axi4l) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

/* logic/cam_sys_regs.sv */
// camera control register bank with byte-masked writes, status sampling and read decode
`timescale 1ns/10ps
`default_nettype none

module cam_sys_regs #(
    parameter logic [15:0]                  CORE_ID            = 16'h5254,
    parameter logic [15:0]                  CORE_VERSION       = 16'h0100,
    parameter bit                           INIT_RECV_RESET    = 1'b1,
    parameter bit                           INIT_ALIGN_RESET   = 1'b1,
    parameter cam_ctrl_pkg::align_pattern_t INIT_ALIGN_PATTERN = 10'h3a6,
    parameter bit                           INIT_CLIP_ENABLE   = 1'b1,
    parameter bit                           INIT_CSI_MODE      = 1'b0,
    parameter cam_ctrl_pkg::csi_dt_t        INIT_CSI_DT        = 8'h2b,
    parameter cam_ctrl_pkg::csi_wc_t        INIT_CSI_WC        = 16'd320
) (
    input  var logic                         s_axi4l,
    input  var logic                         reset,

    input  var logic                         wr_en,
    input  var cam_ctrl_pkg::regadr_t        wr_adr,
    input  var cam_ctrl_pkg::axi_data_t      wr_data,
    input  var cam_ctrl_pkg::axi_strb_t      wr_strb,
    input  var cam_ctrl_pkg::regadr_t        rd_adr,
    output var cam_ctrl_pkg::axi_data_t      rd_data,

    input  var logic                         sensor_ready,
    input  var logic                         align_done,
    input  var logic                         align_error,
    input  var logic                         pll_locked,
    input  var cam_ctrl_pkg::seq_state_t     seq_state,

    output var logic                         power_on,
    output var logic                         recv_reset,
    output var logic                         align_reset,
    output var cam_ctrl_pkg::align_pattern_t align_pattern,
    output var logic                         clip_enable,
    output var logic                         csi_mode,
    output var cam_ctrl_pkg::csi_dt_t        csi_dt,
    output var cam_ctrl_pkg::csi_wc_t        csi_wc
);
    import cam_ctrl_pkg::*;

    logic       smp_sensor_ready;
    logic       smp_pll_locked;
    logic [1:0] smp_align_status;

    // byte lanes without a strobe keep the old value
    function automatic axi_data_t write_mask(
        input axi_data_t org,
        input axi_data_t data,
        input axi_strb_t strb
    );
        axi_data_t merged;
        merged = org;
        for (int i = 0; i < $bits(axi_strb_t); i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    // ----------------------------------------------------------------------
    //  control registers
    // ----------------------------------------------------------------------
    always_ff @(posedge s_axi4l) begin
        if (reset) begin
            power_on      <= 1'b0;
            recv_reset    <= INIT_RECV_RESET;
            align_reset   <= INIT_ALIGN_RESET;
            align_pattern <= INIT_ALIGN_PATTERN;
            clip_enable   <= INIT_CLIP_ENABLE;
            csi_mode      <= INIT_CSI_MODE;
            csi_dt        <= INIT_CSI_DT;
            csi_wc        <= INIT_CSI_WC;
        end else if (wr_en) begin
            case (wr_adr)
                REGADR_POWER_ON:
                    power_on <= 1'(write_mask(axi_data_t'(power_on), wr_data, wr_strb));
                REGADR_RECV_RESET:
                    recv_reset <= 1'(write_mask(axi_data_t'(recv_reset), wr_data, wr_strb));
                REGADR_ALIGN_RESET:
                    align_reset <= 1'(write_mask(axi_data_t'(align_reset), wr_data, wr_strb));
                REGADR_ALIGN_PATTERN:
                    align_pattern <= align_pattern_t'(
                        write_mask(axi_data_t'(align_pattern), wr_data, wr_strb));
                REGADR_CLIP_ENABLE:
                    clip_enable <= 1'(write_mask(axi_data_t'(clip_enable), wr_data, wr_strb));
                REGADR_CSI_MODE:
                    csi_mode <= 1'(write_mask(axi_data_t'(csi_mode), wr_data, wr_strb));
                REGADR_CSI_DT:
                    csi_dt <= csi_dt_t'(write_mask(axi_data_t'(csi_dt), wr_data, wr_strb));
                REGADR_CSI_WC:
                    csi_wc <= csi_wc_t'(write_mask(axi_data_t'(csi_wc), wr_data, wr_strb));
                default: ;
            endcase
        end
    end

    // status inputs come from other blocks, one flop before readback
    always_ff @(posedge s_axi4l) begin
        smp_sensor_ready <= sensor_ready;
        smp_pll_locked   <= pll_locked;
        smp_align_status <= {align_error, align_done};
    end

    // ----------------------------------------------------------------------
    //  read decode
    // ----------------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (rd_adr)
            REGADR_CORE_ID:       rd_data = axi_data_t'(CORE_ID);
            REGADR_CORE_VERSION:  rd_data = axi_data_t'(CORE_VERSION);
            REGADR_POWER_ON:      rd_data = axi_data_t'(power_on);
            REGADR_SEQ_STATUS: begin
                rd_data[2:0] = seq_state;
                rd_data[4]   = smp_pll_locked;
                rd_data[8]   = smp_sensor_ready;
            end
            REGADR_RECV_RESET:    rd_data = axi_data_t'(recv_reset);
            REGADR_ALIGN_RESET:   rd_data = axi_data_t'(align_reset);
            REGADR_ALIGN_PATTERN: rd_data = axi_data_t'(align_pattern);
            REGADR_ALIGN_STATUS:  rd_data = axi_data_t'(smp_align_status);
            REGADR_CLIP_ENABLE:   rd_data = axi_data_t'(clip_enable);
            REGADR_CSI_MODE:      rd_data = axi_data_t'(csi_mode);
            REGADR_CSI_DT:        rd_data = axi_data_t'(csi_dt);
            REGADR_CSI_WC:        rd_data = axi_data_t'(csi_wc);
            default:              rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/sensor_power_seq.sv */
// power-up sequencer releasing PLL and D-PHY resets in order, then enabling the sensor
`timescale 1ns/10ps
`default_nettype none

module sensor_power_seq #(
    parameter int STEP_CYCLES = 8
) (
    input  var logic                     s_axi4l,
    input  var logic                     reset,
    input  var logic                     power_on,
    input  var logic                     pll_locked,
    input  var logic                     dphy_init_done,
    output var logic                     pll_reset,
    output var logic                     dphy_sys_reset,
    output var logic                     dphy_core_reset,
    output var logic                     sensor_enable,
    output var cam_ctrl_pkg::seq_state_t seq_state
);
    import cam_ctrl_pkg::*;

    localparam int CNT_BITS = $clog2(STEP_CYCLES + 1);

    seq_state_t          state_next;
    logic [CNT_BITS-1:0] step_cnt;
    logic                step_done;

    assign step_done = (step_cnt == CNT_BITS'(STEP_CYCLES - 1));

    // ----------------------------------------------------------------------
    //  next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = seq_state;
        if (!power_on) begin
            state_next = SEQ_OFF;
        end else begin
            case (seq_state)
                SEQ_OFF:      state_next = SEQ_PLL_LOCK;
                SEQ_PLL_LOCK: state_next = pll_locked ? SEQ_PHY_SYS : SEQ_PLL_LOCK;
                SEQ_PHY_SYS:  state_next = step_done ? SEQ_PHY_CORE : SEQ_PHY_SYS;
                SEQ_PHY_CORE: state_next = step_done ? SEQ_PHY_INIT : SEQ_PHY_CORE;
                SEQ_PHY_INIT: state_next = dphy_init_done ? SEQ_RUN : SEQ_PHY_INIT;
                SEQ_RUN:      state_next = SEQ_RUN;
                default:      state_next = SEQ_OFF;
            endcase
        end
    end

    // restarts on every state change
    always_ff @(posedge s_axi4l) begin
        if (reset || state_next != seq_state) begin
            step_cnt <= '0;
        end else if (!step_done) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // outputs decoded from the next state so they change with the state
    always_ff @(posedge s_axi4l) begin
        if (reset) begin
            seq_state       <= SEQ_OFF;
            pll_reset       <= 1'b1;
            dphy_sys_reset  <= 1'b1;
            dphy_core_reset <= 1'b1;
            sensor_enable   <= 1'b0;
        end else begin
            seq_state       <= state_next;
            pll_reset       <= (state_next == SEQ_OFF);
            dphy_sys_reset  <= (state_next inside {SEQ_OFF, SEQ_PLL_LOCK, SEQ_PHY_SYS});
            dphy_core_reset <= (state_next inside {SEQ_OFF, SEQ_PLL_LOCK, SEQ_PHY_SYS,
                                                   SEQ_PHY_CORE});
            sensor_enable   <= (state_next == SEQ_RUN);
        end
    end

    // core leaves reset only once the system side has been out for a full step
    a_core_after_sys: assert property (@(posedge s_axi4l) disable iff (reset)
        !dphy_core_reset |-> !dphy_sys_reset && $past(!dphy_sys_reset, STEP_CYCLES));

endmodule

`default_nettype wire

/* logic/cam_sys_ctrl.sv */
// top level of the camera control block, joining the AXI port, register bank and sequencer
`timescale 1ns/10ps
`default_nettype none

module cam_sys_ctrl #(
    parameter logic [15:0]                  CORE_ID            = 16'h5254,
    parameter logic [15:0]                  CORE_VERSION       = 16'h0100,
    parameter bit                           INIT_RECV_RESET    = 1'b1,
    parameter bit                           INIT_ALIGN_RESET   = 1'b1,
    parameter cam_ctrl_pkg::align_pattern_t INIT_ALIGN_PATTERN = 10'h3a6,
    parameter bit                           INIT_CLIP_ENABLE   = 1'b1,
    parameter bit                           INIT_CSI_MODE      = 1'b0,
    parameter cam_ctrl_pkg::csi_dt_t        INIT_CSI_DT        = 8'h2b,
    parameter cam_ctrl_pkg::csi_wc_t        INIT_CSI_WC        = 16'd320,
    parameter int                           STEP_CYCLES        = 8
) (
    input  var logic                         s_axi4l,
    input  var logic                         reset,

    input  var logic                         awvalid,
    output var logic                         awready,
    input  var cam_ctrl_pkg::axi_addr_t      awaddr,
    input  var logic                         wvalid,
    output var logic                         wready,
    input  var cam_ctrl_pkg::axi_data_t      wdata,
    input  var cam_ctrl_pkg::axi_strb_t      wstrb,
    output var logic                         bvalid,
    input  var logic                         bready,
    output var logic [1:0]                   bresp,
    input  var logic                         arvalid,
    output var logic                         arready,
    input  var cam_ctrl_pkg::axi_addr_t      araddr,
    output var logic                         rvalid,
    input  var logic                         rready,
    output var cam_ctrl_pkg::axi_data_t      rdata,
    output var logic [1:0]                   rresp,

    output var logic                         recv_reset,
    output var logic                         align_reset,
    output var cam_ctrl_pkg::align_pattern_t align_pattern,
    output var logic                         clip_enable,
    output var logic                         csi_mode,
    output var cam_ctrl_pkg::csi_dt_t        csi_dt,
    output var cam_ctrl_pkg::csi_wc_t        csi_wc,
    input  var logic                         sensor_ready,
    input  var logic                         align_done,
    input  var logic                         align_error,
    input  var logic                         pll_locked,
    input  var logic                         dphy_init_done,
    output var logic                         pll_reset,
    output var logic                         dphy_sys_reset,
    output var logic                         dphy_core_reset,
    output var logic                         sensor_enable
);
    import cam_ctrl_pkg::*;

    // register strobes from the bus port
    logic       wr_en;
    regadr_t    wr_adr;
    axi_data_t  wr_data;
    axi_strb_t  wr_strb;
    regadr_t    rd_adr;
    axi_data_t  rd_data;

    // bank to sequencer
    logic       power_on;
    seq_state_t seq_state;

    axi4l_reg_port i_axi4l_reg_port (.*);

    cam_sys_regs #(
        .CORE_ID            (CORE_ID),
        .CORE_VERSION       (CORE_VERSION),
        .INIT_RECV_RESET    (INIT_RECV_RESET),
        .INIT_ALIGN_RESET   (INIT_ALIGN_RESET),
        .INIT_ALIGN_PATTERN (INIT_ALIGN_PATTERN),
        .INIT_CLIP_ENABLE   (INIT_CLIP_ENABLE),
        .INIT_CSI_MODE      (INIT_CSI_MODE),
        .INIT_CSI_DT        (INIT_CSI_DT),
        .INIT_CSI_WC        (INIT_CSI_WC)
    ) i_cam_sys_regs (.*);

    sensor_power_seq #(
        .STEP_CYCLES (STEP_CYCLES)
    ) i_sensor_power_seq (.*);

endmodule

`default_nettype wire

/* tests/cam_sys_ctrl_tb.sv */
// testbench for the camera control block, run through sim.f with the Makefile
`timescale 1ns/10ps
`default_nettype none

module cam_sys_ctrl_tb;
    import cam_ctrl_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int STEP_CYCLES = 8;
    // a full run takes about 500 cycles, the watchdog allows twice that
    localparam int WATCHDOG_NS = 2 * 500 * CLK_PERIOD;

    localparam regadr_t RW_REGS [7] = '{REGADR_RECV_RESET, REGADR_ALIGN_RESET,
        REGADR_ALIGN_PATTERN, REGADR_CLIP_ENABLE, REGADR_CSI_MODE, REGADR_CSI_DT,
        REGADR_CSI_WC};
    localparam regadr_t NO_WRITE_REGS [7] = '{REGADR_CORE_ID, REGADR_CORE_VERSION,
        REGADR_SEQ_STATUS, REGADR_ALIGN_STATUS, 8'h02, 8'h30, 8'hff};
    localparam regadr_t PLAIN_REGS [6] = '{REGADR_CORE_ID, REGADR_CORE_VERSION,
        REGADR_POWER_ON, 8'h02, 8'h30, 8'hff};

    logic           s_axi4l = 1'b0;
    logic           reset;
    logic           awvalid, wvalid, arvalid, align_done, align_error;
    logic           awready, wready, bvalid, arready, rvalid;
    logic           bready = 1'b0;
    logic           rready = 1'b0;
    axi_addr_t      awaddr, araddr;
    axi_data_t      wdata, rdata;
    axi_strb_t      wstrb;
    logic [1:0]     bresp, rresp;
    logic           recv_reset, align_reset, clip_enable, csi_mode;
    align_pattern_t align_pattern;
    csi_dt_t        csi_dt;
    csi_wc_t        csi_wc;
    logic           pll_reset, dphy_sys_reset, dphy_core_reset, sensor_enable;
    logic           sensor_ready   = 1'b0;
    logic           pll_locked     = 1'b0;
    logic           dphy_init_done = 1'b0;

    integer     seed = 32'h8513;
    int         cyc = 0;
    int         stall_idx = 0;
    int         t_sys;
    int         pll_delay, init_delay, pll_cnt, init_cnt;
    int         wr_cnt, b_cnt, rd_cnt, r_cnt;
    logic [1:0] stall_pat [64];
    axi_data_t  exp_reg [256];

    cam_sys_ctrl #(
        .STEP_CYCLES (STEP_CYCLES)
    ) i_cam_sys_ctrl (.*);

    initial begin
        forever begin
            #(CLK_PERIOD / 2) s_axi4l = ~s_axi4l;
        end
    end

    // ------------------------------------------------------------------
    //  models around the DUT
    // ------------------------------------------------------------------
    // response stalls replay a pattern drawn at time 0
    always @(posedge s_axi4l) begin
        bready    <= stall_pat[stall_idx][0];
        rready    <= stall_pat[stall_idx][1];
        stall_idx <= (stall_idx + 1) % 64;
        cyc       <= cyc + 1;
    end

    // PLL locks and D-PHY finishes init some cycles after their resets drop
    always @(posedge s_axi4l) begin
        if (reset || pll_reset) begin
            pll_cnt    <= 0;
            pll_locked <= 1'b0;
        end else if (pll_cnt == pll_delay) begin
            pll_locked <= 1'b1;
        end else begin
            pll_cnt <= pll_cnt + 1;
        end
        if (reset || dphy_core_reset) begin
            init_cnt       <= 0;
            dphy_init_done <= 1'b0;
        end else if (init_cnt == init_delay) begin
            dphy_init_done <= 1'b1;
        end else begin
            init_cnt <= init_cnt + 1;
        end
        sensor_ready <= sensor_enable;
    end

    always @(posedge s_axi4l) begin
        if (reset) begin
            wr_cnt <= 0;
            b_cnt  <= 0;
            rd_cnt <= 0;
            r_cnt  <= 0;
        end else begin
            wr_cnt <= wr_cnt + int'(awvalid && awready && wvalid && wready);
            b_cnt  <= b_cnt + int'(bvalid && bready);
            rd_cnt <= rd_cnt + int'(arvalid && arready);
            r_cnt  <= r_cnt + int'(rvalid && rready);
        end
    end

    // ------------------------------------------------------------------
    //  protocol and sequencer assertions
    // ------------------------------------------------------------------
    a_write_resp: assert property (@(posedge s_axi4l) disable iff (reset)
        awvalid && awready && wvalid && wready |=> bvalid)
        else stop_on_error("no bvalid after an accepted write");
    a_bvalid_hold: assert property (@(posedge s_axi4l) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else stop_on_error("bvalid dropped before bready");
    a_read_resp: assert property (@(posedge s_axi4l) disable iff (reset)
        arvalid && arready |=> rvalid)
        else stop_on_error("no rvalid after an accepted read");
    a_rvalid_hold: assert property (@(posedge s_axi4l) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else stop_on_error("rvalid or rdata changed before rready");
    a_resp_count: assert property (@(posedge s_axi4l) disable iff (reset)
        (wr_cnt - b_cnt) inside {0, 1} && (rd_cnt - r_cnt) inside {0, 1})
        else stop_on_error("responses out of step with accepted transfers");
    a_resp_okay: assert property (@(posedge s_axi4l) disable iff (reset)
        bresp == 2'b00 && rresp == 2'b00)
        else stop_on_error("response code other than OKAY");
    a_release_order: assert property (@(posedge s_axi4l) disable iff (reset)
        (dphy_sys_reset || !pll_reset) && (dphy_core_reset || !dphy_sys_reset))
        else stop_on_error("resets released out of order");
    a_enable_after_init: assert property (@(posedge s_axi4l) disable iff (reset)
        sensor_enable |-> dphy_init_done)
        else stop_on_error("sensor enabled before D-PHY init done");

    task automatic stop_on_error(input string msg);
        $display("FAIL %0d ns: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------
    //  AXI tasks
    // ------------------------------------------------------------------
    // returns on the edge that accepts the write, the response drains alone
    task automatic axi_write(input regadr_t adr, input axi_data_t data, input axi_strb_t strb);
        @(posedge s_axi4l);
        awvalid <= 1'b1;
        awaddr  <= {adr, 2'b00};
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        @(negedge s_axi4l);
        while (!(awready && wready)) @(negedge s_axi4l);
        @(posedge s_axi4l);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic axi_read(input regadr_t adr, output axi_data_t data);
        @(posedge s_axi4l);
        arvalid <= 1'b1;
        araddr  <= {adr, 2'b00};
        @(negedge s_axi4l);
        while (!arready) @(negedge s_axi4l);
        @(posedge s_axi4l);
        arvalid <= 1'b0;
        @(negedge s_axi4l);
        while (!(rvalid && rready)) @(negedge s_axi4l);
        data = rdata;
    endtask

    function automatic axi_data_t reg_mask(input regadr_t adr);
        case (adr)
            REGADR_ALIGN_PATTERN: return 32'h0000_03ff;
            REGADR_CSI_DT:        return 32'h0000_00ff;
            REGADR_CSI_WC:        return 32'h0000_ffff;
            REGADR_POWER_ON, REGADR_RECV_RESET, REGADR_ALIGN_RESET,
            REGADR_CLIP_ENABLE, REGADR_CSI_MODE:
                return 32'h0000_0001;
            default:              return '0;
        endcase
    endfunction

    function automatic axi_data_t pin_value(input regadr_t adr);
        case (adr)
            REGADR_RECV_RESET:    return axi_data_t'(recv_reset);
            REGADR_ALIGN_RESET:   return axi_data_t'(align_reset);
            REGADR_ALIGN_PATTERN: return axi_data_t'(align_pattern);
            REGADR_CLIP_ENABLE:   return axi_data_t'(clip_enable);
            REGADR_CSI_MODE:      return axi_data_t'(csi_mode);
            REGADR_CSI_DT:        return axi_data_t'(csi_dt);
            REGADR_CSI_WC:        return axi_data_t'(csi_wc);
            default:              return '0;
        endcase
    endfunction

    // writable bytes take the new data where the strobe is set
    task automatic write_reg(input regadr_t adr, input axi_data_t data, input axi_strb_t strb);
        axi_data_t lanes;
        lanes = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        axi_write(adr, data, strb);
        if (reg_mask(adr) != '0) begin
            exp_reg[adr] = ((exp_reg[adr] & ~lanes) | (data & lanes)) & reg_mask(adr);
        end
    endtask

    task automatic check_read(input regadr_t adr, input axi_data_t expected);
        axi_data_t got;
        axi_read(adr, got);
        assert (got == expected)
            else stop_on_error($sformatf("read %02h gave %08h, expected %08h",
                                         adr, got, expected));
    endtask

    task automatic check_pin(input regadr_t adr);
        assert (pin_value(adr) == exp_reg[adr])
            else stop_on_error($sformatf("pin of %02h is %08h, expected %08h",
                                         adr, pin_value(adr), exp_reg[adr]));
    endtask

    task automatic check_regs;
        @(negedge s_axi4l);
        for (int i = 0; i < $size(RW_REGS); i++) begin
            check_pin(RW_REGS[i]);
        end
        for (int i = 0; i < $size(RW_REGS); i++) begin
            check_read(RW_REGS[i], exp_reg[RW_REGS[i]]);
        end
        for (int i = 0; i < $size(PLAIN_REGS); i++) begin
            check_read(PLAIN_REGS[i], exp_reg[PLAIN_REGS[i]]);
        end
    endtask

    // everything goes back to reset one edge after power_on clears
    task automatic power_off_check;
        write_reg(REGADR_POWER_ON, 32'h0, 4'h1);
        @(negedge s_axi4l);
        assert (!pll_reset) else stop_on_error("sequencer stopped before power_on cleared");
        @(negedge s_axi4l);
        assert (pll_reset && dphy_sys_reset && dphy_core_reset && !sensor_enable)
            else stop_on_error("sequencer outputs not off one edge after power_on cleared");
        repeat (3) @(posedge s_axi4l);
        check_read(REGADR_SEQ_STATUS, 32'h0);
    endtask

    // ------------------------------------------------------------------
    //  test sequence
    // ------------------------------------------------------------------
    initial begin
        reset       = 1'b1;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        arvalid     = 1'b0;
        araddr      = '0;
        align_done  = 1'b0;
        align_error = 1'b0;
        for (int i = 0; i < 64; i++) begin
            stall_pat[i][0] = (($random(seed) & 3) != 0);
            stall_pat[i][1] = (($random(seed) & 3) != 0);
        end
        for (int i = 0; i < 256; i++) begin
            exp_reg[i] = '0;
        end
        exp_reg[REGADR_CORE_ID]       = 32'h0000_5254;
        exp_reg[REGADR_CORE_VERSION]  = 32'h0000_0100;
        exp_reg[REGADR_RECV_RESET]    = 32'h1;
        exp_reg[REGADR_ALIGN_RESET]   = 32'h1;
        exp_reg[REGADR_ALIGN_PATTERN] = 32'h3a6;
        exp_reg[REGADR_CLIP_ENABLE]   = 32'h1;
        exp_reg[REGADR_CSI_DT]        = 32'h2b;
        exp_reg[REGADR_CSI_WC]        = 32'd320;
        repeat (10) @(posedge s_axi4l);
        reset <= 1'b0;

        @(negedge s_axi4l);
        assert (pll_reset && dphy_sys_reset && dphy_core_reset && !sensor_enable)
            else stop_on_error("sequencer outputs not off after reset");
        check_regs();

        for (int round = 0; round < 3; round++) begin
            for (int i = 0; i < $size(RW_REGS); i++) begin
                write_reg(RW_REGS[i], axi_data_t'($random(seed)), axi_strb_t'($random(seed)));
                @(negedge s_axi4l);
                check_pin(RW_REGS[i]);
                check_read(RW_REGS[i], exp_reg[RW_REGS[i]]);
            end
        end

        // read-only and unused offsets, status from the aligner model
        @(posedge s_axi4l);
        align_done <= 1'b1;
        for (int i = 0; i < $size(NO_WRITE_REGS); i++) begin
            write_reg(NO_WRITE_REGS[i], 32'hffff_ffff, 4'hf);
        end
        check_regs();
        check_read(REGADR_ALIGN_STATUS, 32'h1);
        check_read(REGADR_SEQ_STATUS, 32'h0);
        @(posedge s_axi4l);
        align_done  <= 1'b0;
        align_error <= 1'b1;
        repeat (2) @(posedge s_axi4l);
        check_read(REGADR_ALIGN_STATUS, 32'h2);

        // full power-up
        pll_delay  = 1 + ($random(seed) & 15);
        init_delay = 1 + ($random(seed) & 15);
        write_reg(REGADR_POWER_ON, 32'h1, 4'h1);
        @(negedge s_axi4l);
        while (pll_reset) @(negedge s_axi4l);
        while (dphy_sys_reset) @(negedge s_axi4l);
        t_sys = cyc;
        while (dphy_core_reset) @(negedge s_axi4l);
        assert (cyc - t_sys >= STEP_CYCLES)
            else stop_on_error($sformatf("D-PHY resets released %0d cycles apart", cyc - t_sys));
        while (!sensor_enable) @(negedge s_axi4l);
        repeat (3) @(posedge s_axi4l);
        check_read(REGADR_SEQ_STATUS, 32'h115);
        check_read(REGADR_POWER_ON, 32'h1);
        power_off_check();

        // power_on cleared again while the D-PHY is still coming up
        pll_delay  = 1 + ($random(seed) & 15);
        init_delay = 20;
        write_reg(REGADR_POWER_ON, 32'h1, 4'h1);
        @(negedge s_axi4l);
        while (dphy_sys_reset) @(negedge s_axi4l);
        power_off_check();

        @(negedge s_axi4l);
        while (bvalid || rvalid) @(negedge s_axi4l);
        assert (wr_cnt == b_cnt && rd_cnt == r_cnt)
            else stop_on_error($sformatf("%0d writes got %0d responses, %0d reads got %0d",
                                         wr_cnt, b_cnt, rd_cnt, r_cnt));
        $display("sim passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a handshake or the sequencer got stuck",
                 WATCHDOG_NS);
        $display("sim failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* sim.f */
logic/cam_ctrl_pkg.sv
logic/axi4l_reg_port.sv
logic/cam_sys_regs.sv
logic/sensor_power_seq.sv
logic/cam_sys_ctrl.sv
tests/cam_sys_ctrl_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = cam_sys_ctrl_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf $(OBJ_DIR)
